// File: source/apb_bus_pkg.sv
// APB bus widths and the vector types built on them
// Shared by the bridge RTL and the testbench, always through scoped names
`default_nettype none

package apb_bus_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------

    // Byte address width on PADDR
    localparam int ADDRESS_WIDTH = 32;

    // Width of PWDATA and PRDATA
    localparam int DATA_WIDTH = 32;

    // One strobe bit per data byte
    localparam int DATA_STROBE = DATA_WIDTH / 8;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------

    // Byte address of one transfer
    typedef logic [ADDRESS_WIDTH-1:0] apb_addr_t;

    // One data word, write or read
    typedef logic [DATA_WIDTH-1:0] apb_data_t;

    // Byte enables, bit n covers data bits [8n+7:8n]
    typedef logic [DATA_STROBE-1:0] apb_strb_t;

endpackage

`default_nettype wire

// File: source/bridge_cfg_pkg.sv
// Configuration defaults and internal types of the APB bridge
// Holds the queued command layout and the transfer FSM states
`default_nettype none

package bridge_cfg_pkg;

    // Commands the queue can hold between capture and the bus
    localparam int DEFAULT_FIFO_DEPTH = 4;

    // Access cycles allowed before a transfer is abandoned
    localparam int DEFAULT_TIMEOUT_CYCLES = 16;

    // Access cycle counter, wide enough for the timeout limit
    typedef logic [7:0] wait_count_t;

    // One queued command, 69 bits, write flag in the top bit
    typedef struct packed {
        logic                  is_write;
        apb_bus_pkg::apb_addr_t addr;
        apb_bus_pkg::apb_strb_t strb;
        apb_bus_pkg::apb_data_t wdata;
    } req_entry_t;

    // APB transfer phases
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } xfer_state_t;

endpackage

`default_nettype wire

// File: source/cpu_request_capture.sv
// Capture stage of the APB bridge
// Registers one CPU command and offers it to the request queue,
// holding it and dropping apb_ready_for_txn while the queue is full
`timescale 1ns/100ps
`default_nettype none

module cpu_request_capture (
    input  wire logic                   PCLK,
    input  wire logic                   rst_n,
    input  wire logic                   from_cpu_valid_txn,
    input  wire logic                   from_cpu_rd_wr,
    input  wire apb_bus_pkg::apb_addr_t from_cpu_address,
    input  wire apb_bus_pkg::apb_strb_t from_cpu_wr_strb,
    input  wire apb_bus_pkg::apb_data_t from_cpu_wr_wdata,
    input  wire logic                   full,
    output logic                        apb_ready_for_txn,
    output logic                        cap_valid,
    output bridge_cfg_pkg::req_entry_t  cap_entry
);

    logic ready_en;
    logic accept;
    logic hand_off;

    // Entry moves into the queue on this edge
    assign hand_off = cap_valid && !full;

    // Room when empty, or when the held entry leaves now
    assign apb_ready_for_txn = ready_en && (!cap_valid || hand_off);
    assign accept = from_cpu_valid_txn && apb_ready_for_txn;

    always_ff @(posedge PCLK)
    begin
        if (!rst_n)
        begin
            ready_en  <= 1'b0;
            cap_valid <= 1'b0;
        end
        else
        begin
            ready_en <= 1'b1;
            if (accept)
                cap_valid <= 1'b1;
            else if (hand_off)
                cap_valid <= 1'b0;
        end
    end

    // Command register, strobe cleared for reads
    always_ff @(posedge PCLK)
    begin
        if (accept)
        begin
            cap_entry.is_write <= from_cpu_rd_wr;
            cap_entry.addr     <= from_cpu_address;
            cap_entry.strb     <= from_cpu_rd_wr ? from_cpu_wr_strb : '0;
            cap_entry.wdata    <= from_cpu_wr_wdata;
        end
    end

    // A stalled command must reach the queue unchanged
    a_hold_while_full : assert property (@(posedge PCLK) disable iff (!rst_n)
        cap_valid && full |=> $stable(cap_entry));

endmodule

`default_nettype wire

// File: source/request_fifo.sv
// Request queue of the APB bridge
// Circular buffer of captured commands, read in arrival order.
// A push and a pop may happen on the same edge
`timescale 1ns/100ps
`default_nettype none

module request_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                       PCLK,
    input  wire logic                       rst_n,
    input  wire logic                       push,
    input  wire bridge_cfg_pkg::req_entry_t push_entry,
    input  wire logic                       pop,
    output bridge_cfg_pkg::req_entry_t      head_entry,
    output logic                            full,
    output logic                            empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

    bridge_cfg_pkg::req_entry_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // --------------------------------------------------
    // Status and head
    // --------------------------------------------------
    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_entry = mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge PCLK)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            // both together leave the count as it is
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge PCLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_entry;
    end

    // Transfer FSM only pops a queued command
    a_no_pop_empty : assert property (@(posedge PCLK) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// File: source/apb_transfer_fsm.sv
// APB transfer stage of the bridge
// Pops queued commands, runs each one as a setup/access transfer and
// returns read data, slave error or timeout with a one-cycle done pulse
`timescale 1ns/100ps
`default_nettype none

module apb_transfer_fsm #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  wire logic                       PCLK,
    input  wire logic                       rst_n,
    input  wire logic                       empty,
    input  wire bridge_cfg_pkg::req_entry_t head_entry,
    input  wire logic                       pready,
    input  wire apb_bus_pkg::apb_data_t     prdata,
    input  wire logic                       pslverr,
    output logic                            pop,
    output logic                            psel,
    output logic                            penable,
    output logic                            pwrite,
    output apb_bus_pkg::apb_addr_t          paddr,
    output apb_bus_pkg::apb_data_t          pwdata,
    output apb_bus_pkg::apb_strb_t          pstrb,
    output apb_bus_pkg::apb_data_t          to_cpu_rdata,
    output logic                            to_cpu_rdata_valid_wdata_done,
    output logic                            to_cpu_txn_err,
    output logic                            to_cpu_txn_timeout
);

    // Value of the counter on the last allowed access cycle
    localparam bridge_cfg_pkg::wait_count_t WAIT_LIMIT =
        bridge_cfg_pkg::wait_count_t'(TIMEOUT_CYCLES - 1);

    bridge_cfg_pkg::xfer_state_t state;
    bridge_cfg_pkg::wait_count_t wait_cnt;

    logic last_wait;
    logic xfer_end;
    logic xfer_ok;

    // --------------------------------------------------
    // Phase decode
    // --------------------------------------------------
    assign pop     = (state == bridge_cfg_pkg::IDLE) && !empty;
    assign psel    = (state != bridge_cfg_pkg::IDLE);
    assign penable = (state == bridge_cfg_pkg::ACCESS);

    assign last_wait = (wait_cnt == WAIT_LIMIT);
    assign xfer_end  = penable && (pready || last_wait);
    // pready on the last allowed cycle still counts as a completion
    assign xfer_ok   = penable && pready;

    // --------------------------------------------------
    // Transfer FSM
    // --------------------------------------------------
    always_ff @(posedge PCLK)
    begin
        if (!rst_n)
        begin
            state    <= bridge_cfg_pkg::IDLE;
            wait_cnt <= '0;
        end
        else
        begin
            case (state)
                bridge_cfg_pkg::IDLE:
                begin
                    if (pop)
                        state <= bridge_cfg_pkg::SETUP;
                end
                bridge_cfg_pkg::SETUP:
                begin
                    state    <= bridge_cfg_pkg::ACCESS;
                    wait_cnt <= '0;
                end
                bridge_cfg_pkg::ACCESS:
                begin
                    if (xfer_end)
                        state <= bridge_cfg_pkg::IDLE;
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                default:
                    state <= bridge_cfg_pkg::IDLE;
            endcase
        end
    end

    // Popped command drives the bus for the whole transfer
    always_ff @(posedge PCLK)
    begin
        if (pop)
        begin
            pwrite <= head_entry.is_write;
            paddr  <= head_entry.addr;
            pwdata <= head_entry.wdata;
            pstrb  <= head_entry.strb;
        end
    end

    // --------------------------------------------------
    // Response to the CPU side
    // --------------------------------------------------
    always_ff @(posedge PCLK)
    begin
        if (!rst_n)
        begin
            to_cpu_rdata_valid_wdata_done <= 1'b0;
            to_cpu_txn_err                <= 1'b0;
            to_cpu_txn_timeout            <= 1'b0;
        end
        else
        begin
            to_cpu_rdata_valid_wdata_done <= xfer_end;
            to_cpu_txn_err                <= xfer_ok && pslverr;
            to_cpu_txn_timeout            <= xfer_end && !pready;
        end
    end

    // Zero unless a read completes
    always_ff @(posedge PCLK)
    begin
        to_cpu_rdata <= (xfer_ok && !pwrite) ? prdata : '0;
    end

    a_enable_in_sel : assert property (@(posedge PCLK) disable iff (!rst_n)
        penable |-> psel);

    // Address and control hold from SETUP until the transfer ends
    a_stable_xfer : assert property (@(posedge PCLK) disable iff (!rst_n)
        psel && !xfer_end |=>
            psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

`default_nettype wire

// File: source/apb_bridge_top.sv
// APB bridge top level
// Chains the capture stage, the request queue and the transfer FSM.
// Queue depth and timeout are set here and passed down
`timescale 1ns/100ps
`default_nettype none

module apb_bridge_top #(
    parameter int FIFO_DEPTH     = bridge_cfg_pkg::DEFAULT_FIFO_DEPTH,
    parameter int TIMEOUT_CYCLES = bridge_cfg_pkg::DEFAULT_TIMEOUT_CYCLES
) (
    input  wire logic                   PCLK,
    input  wire logic                   rst_n,
    // CPU side
    input  wire logic                   from_cpu_valid_txn,
    input  wire logic                   from_cpu_rd_wr,
    input  wire apb_bus_pkg::apb_addr_t from_cpu_address,
    input  wire apb_bus_pkg::apb_strb_t from_cpu_wr_strb,
    input  wire apb_bus_pkg::apb_data_t from_cpu_wr_wdata,
    output logic                        apb_ready_for_txn,
    output apb_bus_pkg::apb_data_t      to_cpu_rdata,
    output logic                        to_cpu_rdata_valid_wdata_done,
    output logic                        to_cpu_txn_err,
    output logic                        to_cpu_txn_timeout,
    // APB side
    output logic                        psel,
    output logic                        penable,
    output logic                        pwrite,
    output apb_bus_pkg::apb_addr_t      paddr,
    output apb_bus_pkg::apb_data_t      pwdata,
    output apb_bus_pkg::apb_strb_t      pstrb,
    input  wire logic                   pready,
    input  wire apb_bus_pkg::apb_data_t prdata,
    input  wire logic                   pslverr
);

    logic                       cap_valid;
    bridge_cfg_pkg::req_entry_t cap_entry;
    logic                       full;
    logic                       empty;
    logic                       pop;
    bridge_cfg_pkg::req_entry_t head_entry;

    cpu_request_capture i_cpu_request_capture (
        .PCLK              (PCLK),
        .rst_n             (rst_n),
        .from_cpu_valid_txn(from_cpu_valid_txn),
        .from_cpu_rd_wr    (from_cpu_rd_wr),
        .from_cpu_address  (from_cpu_address),
        .from_cpu_wr_strb  (from_cpu_wr_strb),
        .from_cpu_wr_wdata (from_cpu_wr_wdata),
        .full              (full),
        .apb_ready_for_txn (apb_ready_for_txn),
        .cap_valid         (cap_valid),
        .cap_entry         (cap_entry)
    );

    request_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_request_fifo (
        .PCLK      (PCLK),
        .rst_n     (rst_n),
        .push      (cap_valid),
        .push_entry(cap_entry),
        .pop       (pop),
        .head_entry(head_entry),
        .full      (full),
        .empty     (empty)
    );

    apb_transfer_fsm #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) i_apb_transfer_fsm (
        .PCLK                         (PCLK),
        .rst_n                        (rst_n),
        .empty                        (empty),
        .head_entry                   (head_entry),
        .pready                       (pready),
        .prdata                       (prdata),
        .pslverr                      (pslverr),
        .pop                          (pop),
        .psel                         (psel),
        .penable                      (penable),
        .pwrite                       (pwrite),
        .paddr                        (paddr),
        .pwdata                       (pwdata),
        .pstrb                        (pstrb),
        .to_cpu_rdata                 (to_cpu_rdata),
        .to_cpu_rdata_valid_wdata_done(to_cpu_rdata_valid_wdata_done),
        .to_cpu_txn_err               (to_cpu_txn_err),
        .to_cpu_txn_timeout           (to_cpu_txn_timeout)
    );

endmodule

`default_nettype wire

// File: verif/tb_apb_bridge.sv
// Self-checking testbench for the APB bridge
// Drives CPU commands, models a 16-word APB slave with random wait states,
// and checks every done pulse against a reference model in issue order
`timescale 1ns/100ps
`default_nettype none

module tb_apb_bridge;

    localparam int CLK_PERIOD      = 8;
    localparam int TIMEOUT_CYCLES  = bridge_cfg_pkg::DEFAULT_TIMEOUT_CYCLES;
    localparam int NUM_CMDS        = 36;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * (TIMEOUT_CYCLES + 8) + 50;

    // Slave address map
    localparam apb_bus_pkg::apb_addr_t MEM_END   = 32'h40;
    localparam apb_bus_pkg::apb_addr_t ERR_BASE  = 32'h100;
    localparam apb_bus_pkg::apb_addr_t HANG_BASE = 32'h200;

    logic                   PCLK;
    logic                   rst_n;
    logic                   from_cpu_valid_txn;
    logic                   from_cpu_rd_wr;
    apb_bus_pkg::apb_addr_t from_cpu_address;
    apb_bus_pkg::apb_strb_t from_cpu_wr_strb;
    apb_bus_pkg::apb_data_t from_cpu_wr_wdata;
    logic                   apb_ready_for_txn;
    apb_bus_pkg::apb_data_t to_cpu_rdata;
    logic                   to_cpu_rdata_valid_wdata_done;
    logic                   to_cpu_txn_err;
    logic                   to_cpu_txn_timeout;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    apb_bus_pkg::apb_addr_t paddr;
    apb_bus_pkg::apb_data_t pwdata;
    apb_bus_pkg::apb_strb_t pstrb;
    logic                   pready;
    apb_bus_pkg::apb_data_t prdata;
    logic                   pslverr;

    // Expected response layout {timeout, err, rdata}
    logic [33:0]            exp_q[$];
    logic [33:0]            exp_resp;
    apb_bus_pkg::apb_data_t slave_mem[16];
    apb_bus_pkg::apb_data_t shadow[16];
    apb_bus_pkg::apb_strb_t strb_set[4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    integer                 seed = 7;
    int                     wait_left;
    logic                   max_wait;
    logic                   saw_stall;
    int                     err_count;
    int                     test_err_base;
    int                     pass_count;
    int                     fail_count;

    apb_bridge_top #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) i_apb_bridge_top (
        .PCLK                         (PCLK),
        .rst_n                        (rst_n),
        .from_cpu_valid_txn           (from_cpu_valid_txn),
        .from_cpu_rd_wr               (from_cpu_rd_wr),
        .from_cpu_address             (from_cpu_address),
        .from_cpu_wr_strb             (from_cpu_wr_strb),
        .from_cpu_wr_wdata            (from_cpu_wr_wdata),
        .apb_ready_for_txn            (apb_ready_for_txn),
        .to_cpu_rdata                 (to_cpu_rdata),
        .to_cpu_rdata_valid_wdata_done(to_cpu_rdata_valid_wdata_done),
        .to_cpu_txn_err               (to_cpu_txn_err),
        .to_cpu_txn_timeout           (to_cpu_txn_timeout),
        .psel                         (psel),
        .penable                      (penable),
        .pwrite                       (pwrite),
        .paddr                        (paddr),
        .pwdata                       (pwdata),
        .pstrb                        (pstrb),
        .pready                       (pready),
        .prdata                       (prdata),
        .pslverr                      (pslverr)
    );

    always #(CLK_PERIOD / 2) PCLK = ~PCLK;

    // --------------------------------------------------
    // Helpers and reference model
    // --------------------------------------------------
    function automatic apb_bus_pkg::apb_data_t fill_word(input apb_bus_pkg::apb_addr_t addr);
        return 32'hC0DE_0000 ^ (addr * 32'h0001_0003);
    endfunction

    // Byte lane n taken from the new word when strobe bit n is set
    function automatic apb_bus_pkg::apb_data_t merge_bytes(input apb_bus_pkg::apb_data_t old,
        input apb_bus_pkg::apb_data_t data, input apb_bus_pkg::apb_strb_t strb);
        apb_bus_pkg::apb_data_t word;
        word = old;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    function automatic logic [33:0] expected_response(input logic is_write,
        input apb_bus_pkg::apb_addr_t addr);
        if (addr >= HANG_BASE)
            return {1'b1, 1'b0, 32'h0};
        if (addr >= ERR_BASE)
            return {1'b0, 1'b1, 32'h0};
        if (is_write)
            return '0;
        return {2'b00, shadow[addr[5:2]]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    // Holds the command until the capture stage takes it
    task automatic issue_cmd(input logic is_write, input apb_bus_pkg::apb_addr_t addr,
        input apb_bus_pkg::apb_strb_t strb, input apb_bus_pkg::apb_data_t data);
        logic accepted;
        exp_q.push_back(expected_response(is_write, addr));
        if (is_write && addr < MEM_END)
            shadow[addr[5:2]] = merge_bytes(shadow[addr[5:2]], data, strb);
        from_cpu_valid_txn = 1'b1;
        from_cpu_rd_wr     = is_write;
        from_cpu_address   = addr;
        from_cpu_wr_strb   = strb;
        from_cpu_wr_wdata  = data;
        accepted = 1'b0;
        while (!accepted)
        begin
            accepted = apb_ready_for_txn;
            if (!accepted)
                saw_stall = 1'b1;
            @(posedge PCLK);
            #1;
        end
        from_cpu_valid_txn = 1'b0;
    endtask

    task automatic start_test();
        test_err_base = err_count;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0)
        begin
            @(posedge PCLK);
            #1;
        end
        if (err_count == test_err_base)
        begin
            pass_count++;
            $display("test %s: ok", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: %0d errors", name, err_count - test_err_base);
        end
    endtask

    // --------------------------------------------------
    // APB slave model
    // --------------------------------------------------
    always @(posedge PCLK)
    begin
        #1;
        pready  = 1'b0;
        pslverr = 1'b0;
        prdata  = '0;
        if (psel && !penable)
            wait_left = max_wait ? 3 : ($random(seed) & 3);
        else if (psel && penable && paddr < HANG_BASE)
        begin
            if (wait_left > 0)
                wait_left--;
            else
            begin
                pready = 1'b1;
                if (paddr >= ERR_BASE)
                    pslverr = 1'b1;
                else if (pwrite)
                    slave_mem[paddr[5:2]] = merge_bytes(slave_mem[paddr[5:2]], pwdata, pstrb);
                else
                    prdata = slave_mem[paddr[5:2]];
            end
        end
        if (psel === 1'b1 && !pwrite)
            check_value("pstrb", 0, 32'(pstrb));
    end

    // Response checker, sampled away from the clock edge
    always @(negedge PCLK)
    begin
        if (rst_n && to_cpu_rdata_valid_wdata_done)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Done pulse at %0t with no command outstanding", $time);
                err_count++;
            end
            else
            begin
                exp_resp = exp_q.pop_front();
                check_value("to_cpu_rdata", exp_resp[31:0], to_cpu_rdata);
                check_value("to_cpu_txn_err", 32'(exp_resp[32]), 32'(to_cpu_txn_err));
                check_value("to_cpu_txn_timeout", 32'(exp_resp[33]), 32'(to_cpu_txn_timeout));
            end
        end
        else if (rst_n && (to_cpu_txn_err || to_cpu_txn_timeout))
        begin
            $display("Error or timeout pulse at %0t without a done pulse", $time);
            err_count++;
        end
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run hung, %0d responses still outstanding", exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial
    begin
        PCLK = 1'b0;
        rst_n = 1'b0;
        from_cpu_valid_txn = 1'b0;
        from_cpu_rd_wr = 1'b0;
        from_cpu_address = '0;
        from_cpu_wr_strb = '0;
        from_cpu_wr_wdata = '0;
        pready = 1'b0;
        prdata = '0;
        pslverr = 1'b0;
        max_wait = 1'b0;
        saw_stall = 1'b0;
        wait_left = 0;
        err_count = 0;
        pass_count = 0;
        fail_count = 0;
        for (int w = 0; w < 16; w++)
        begin
            slave_mem[w] = fill_word(32'(w * 4));
            shadow[w]    = fill_word(32'(w * 4));
        end

        repeat (3) @(posedge PCLK);
        #1;
        start_test();
        check_value("psel", 0, 32'(psel));
        check_value("penable", 0, 32'(penable));
        check_value("apb_ready_for_txn", 0, 32'(apb_ready_for_txn));
        check_value("to_cpu_rdata_valid_wdata_done", 0, 32'(to_cpu_rdata_valid_wdata_done));
        check_value("to_cpu_txn_err", 0, 32'(to_cpu_txn_err));
        check_value("to_cpu_txn_timeout", 0, 32'(to_cpu_txn_timeout));
        rst_n = 1'b1;
        @(posedge PCLK);
        #1;
        check_value("apb_ready_for_txn", 1, 32'(apb_ready_for_txn));
        finish_test("reset_values");

        start_test();
        for (int i = 0; i < 6; i++)
            issue_cmd(1'b1, 32'(4 * i), 4'hF, 32'hA5A5_0000 ^ (i * 32'h0101_0101));
        for (int i = 0; i < 6; i++)
            issue_cmd(1'b0, 32'(4 * i), 4'hF, 32'h0);
        finish_test("full_writes");

        start_test();
        for (int i = 0; i < 4; i++)
            issue_cmd(1'b1, 32'(32 + 4 * i), strb_set[i], 32'h1234_5678 + i);
        for (int i = 0; i < 4; i++)
            issue_cmd(1'b0, 32'(32 + 4 * i), 4'hF, 32'hFFFF_FFFF);
        finish_test("partial_strobes");

        start_test();
        issue_cmd(1'b0, 32'h100, 4'hF, 32'h0);
        issue_cmd(1'b1, 32'h104, 4'hF, 32'hDEAD_BEEF);
        issue_cmd(1'b0, 32'h004, 4'hF, 32'h0);
        finish_test("slave_error");

        start_test();
        issue_cmd(1'b0, 32'h200, 4'hF, 32'h0);
        issue_cmd(1'b1, 32'h300, 4'hF, 32'h5555_AAAA);
        issue_cmd(1'b0, 32'h008, 4'hF, 32'h0);
        finish_test("timeout");

        // Slowest slave so the queue fills and the capture stage stalls
        start_test();
        max_wait = 1'b1;
        saw_stall = 1'b0;
        for (int i = 0; i < 10; i++)
        begin
            if (i < 5)
                issue_cmd(1'b1, 32'(44 + 4 * i), 4'hF, 32'hB000_0000 + i * 32'h1111);
            else
                issue_cmd(1'b0, 32'(44 + 4 * (i - 5)), 4'hF, 32'h0);
        end
        if (!saw_stall)
        begin
            $display("apb_ready_for_txn never went low during the burst");
            err_count++;
        end
        finish_test("burst_backpressure");

        $display("tests passed %0d, failed %0d, check errors %0d",
            pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/apb_bus_pkg.sv
source/bridge_cfg_pkg.sv
source/cpu_request_capture.sv
source/request_fifo.sv
source/apb_transfer_fsm.sv
source/apb_bridge_top.sv
verif/tb_apb_bridge.sv

// File: Makefile
# Verilator build and run for the APB bridge testbench

TOP       ?= tb_apb_bridge
VERILATOR ?= verilator
LOG       ?= run.log
FLAGS     ?= --assert
FILELIST  := build.f
BIN       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
